// File: src/fetch_pkg.sv
//##########################################################################
// fetch package
// shared widths, bus and pipeline structs, master state encoding and
// constants of the RV32 instruction-fetch front end
//##########################################################################
package fetch_pkg;

    typedef logic [31:0] pc_t;      // byte address of an instruction
    typedef logic [31:0] inst_t;    // raw 32-bit instruction word

    localparam int    ROM_WORDS = 32;
    localparam int    ROM_AW    = 5;             // word index width
    localparam pc_t   RESET_PC  = 32'h0000_0000;
    localparam inst_t NOP_INST  = 32'h0000_0013; // addi x0,x0,0

    // APB master to slave
    typedef struct packed {
        logic psel;
        logic penable;
        pc_t  paddr;
    } apb_req_t;

    // APB slave to master
    typedef struct packed {
        inst_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    // one fetched instruction on its way to decode
    typedef struct packed {
        pc_t   pc;
        inst_t inst;
        logic  fault;   // pslverr seen on the read
        logic  valid;
    } fetch_pkt_t;

    // commands from decode and execute
    typedef struct packed {
        logic flush;    // redirect from execute
        logic bubble;   // empty slot, keep the word
        logic stall;    // decode holds IF/ID
    } pipe_ctrl_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        HOLD
    } fetch_state_e;

endpackage

// File: src/pc_gen.sv
//##########################################################################
// pc_gen
// program counter of the fetch stage, a loadable counter that steps by
// one word per issued fetch and takes redirect targets from execute
//##########################################################################
`timescale 1ns/1ps

module pc_gen
    import fetch_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic pc_step,       // fetch issued this cycle
    input  logic redirect,
    input  pc_t  redirect_pc,
    output pc_t  fetch_pc
);

    pc_t pc_next;
    pc_t target;

    // no compressed instructions, so targets are word aligned
    assign target = {redirect_pc[31:2], 2'b00};

    always_comb begin
        pc_next = fetch_pc;
        if (redirect) begin
            pc_next = target;           // redirect wins over step
        end else if (pc_step) begin
            pc_next = fetch_pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pc <= RESET_PC;
        end else begin
            fetch_pc <= pc_next;
        end
    end

endmodule

// File: src/fetch_fsm.sv
//##########################################################################
// fetch_fsm
// APB read master of the fetch stage. Issues one word read at a time,
// tags the returned data with its pc, drops reads made stale by a
// redirect and buffers a finished read until IF/ID takes it
//##########################################################################
`timescale 1ns/1ps

module fetch_fsm
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  pipe_ctrl_t ctrl,
    input  pc_t        fetch_pc,
    input  logic       take,
    output logic       pc_step,
    output apb_req_t   apb_req,
    input  apb_rsp_t   apb_rsp,
    output fetch_pkt_t if_pkt,
    output logic       fetch_stall_req
);

    fetch_state_e state;
    fetch_state_e state_next;
    pc_t          req_pc;       // address of the read on the bus
    logic         discard;      // read in flight belongs to the old path
    inst_t        hold_inst;
    logic         hold_fault;
    logic         done;
    logic         pkt_valid;

    assign done = (state == ACCESS) && apb_rsp.pready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // wait one cycle while pc_gen loads a redirect
                if (!ctrl.flush)
                    state_next = SETUP;
            end
            SETUP: begin
                state_next = ACCESS;    // APB cannot abort after setup
            end
            ACCESS: begin
                if (done) begin
                    if (ctrl.flush)
                        state_next = IDLE;
                    else if (discard || take)
                        state_next = SETUP;
                    else
                        state_next = HOLD;
                end
            end
            HOLD: begin
                if (ctrl.flush)
                    state_next = IDLE;  // held word is dropped
                else if (take)
                    state_next = SETUP;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            discard <= 1'b0;
        end else begin
            state <= state_next;
            if (done)
                discard <= 1'b0;
            else if (ctrl.flush && (state == SETUP || state == ACCESS))
                discard <= 1'b1;
        end
    end

    // address latch and response buffer
    always_ff @(posedge clk) begin
        if (state_next == SETUP)
            req_pc <= fetch_pc;
        if (done) begin
            hold_inst  <= apb_rsp.prdata;
            hold_fault <= apb_rsp.pslverr;
        end
    end

    assign pc_step = (state == SETUP);  // pc moves on once the address is out

    assign apb_req.psel    = (state == SETUP) || (state == ACCESS);
    assign apb_req.penable = (state == ACCESS);
    assign apb_req.paddr   = req_pc;

    assign pkt_valid = (done && !discard) || (state == HOLD);

    always_comb begin
        if_pkt.pc    = req_pc;
        if_pkt.valid = pkt_valid;
        if (state == HOLD) begin
            if_pkt.inst  = hold_inst;
            if_pkt.fault = hold_fault;
        end else if (pkt_valid) begin
            if_pkt.inst  = apb_rsp.prdata;      // straight from the bus
            if_pkt.fault = apb_rsp.pslverr;
        end else begin
            if_pkt.inst  = NOP_INST;
            if_pkt.fault = 1'b0;
        end
    end

    assign fetch_stall_req = !pkt_valid;  // nothing new for decode

endmodule

// File: src/inst_rom.sv
//##########################################################################
// inst_rom
// APB read-only instruction memory, word indexed, with wait states
// taken from address bits 3:2 and counted down during the access phase
//##########################################################################
`timescale 1ns/1ps

module inst_rom
    import fetch_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    inst_t             mem [ROM_WORDS];
    logic [1:0]        wait_cnt;        // access cycles left before pready
    logic [ROM_AW-1:0] word_idx;
    logic              in_range;
    logic              setup_ph;
    logic              access_ph;

    initial begin
        $readmemh("src/inst_rom.hex", mem);
    end

    assign setup_ph  = apb_req.psel && !apb_req.penable;
    assign access_ph = apb_req.psel && apb_req.penable;

    assign word_idx = apb_req.paddr[ROM_AW+1:2];
    assign in_range = (apb_req.paddr[31:2] < 30'(ROM_WORDS));

    // wait-state timer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= 2'd0;
        end else if (setup_ph) begin
            wait_cnt <= apb_req.paddr[3:2];
        end else if (access_ph && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    assign apb_rsp.pready  = access_ph && (wait_cnt == 2'd0);
    assign apb_rsp.pslverr = apb_rsp.pready && !in_range;   // outside the ROM
    assign apb_rsp.prdata  = in_range ? mem[word_idx] : NOP_INST;

endmodule

// File: src/if_id_reg.sv
//##########################################################################
// if_id_reg
// IF/ID pipeline register. Flush clears it, stall holds it, bubble
// inserts an empty slot, otherwise it captures the fetch packet
//##########################################################################
`timescale 1ns/1ps

module if_id_reg
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  pipe_ctrl_t ctrl,
    input  fetch_pkt_t if_pkt,
    output logic       take,
    output fetch_pkt_t id
);

    fetch_pkt_t empty_pkt;
    logic       capture;

    // invalid nop at pc zero
    always_comb begin
        empty_pkt       = '0;
        empty_pkt.inst  = NOP_INST;
    end

    // priority as in the pipeline: flush, stall, bubble, capture
    assign capture = !ctrl.flush && !ctrl.stall && !ctrl.bubble;

    // word consumed, fetch may move on
    assign take = if_pkt.valid && capture;

    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.flush) begin
            id <= empty_pkt;
        end else if (ctrl.stall) begin
            id <= id;                   // decode not ready
        end else if (ctrl.bubble) begin
            id <= empty_pkt;
        end else begin
            id <= if_pkt;
        end
    end

endmodule

// File: src/fetch_top.sv
//##########################################################################
// fetch_top
// instruction-fetch front end: pc counter, APB fetch master, instruction
// ROM and the IF/ID register
//##########################################################################
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  pipe_ctrl_t ctrl,
    input  pc_t        redirect_pc,
    output fetch_pkt_t id,
    output logic       fetch_stall_req
);

    pc_t        fetch_pc;
    logic       pc_step;
    logic       take;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    fetch_pkt_t if_pkt;

    pc_gen u_pc_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_step     (pc_step),
        .redirect    (ctrl.flush),  // every flush carries a target
        .redirect_pc (redirect_pc),
        .fetch_pc    (fetch_pc)
    );

    fetch_fsm u_fetch_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctrl            (ctrl),
        .fetch_pc        (fetch_pc),
        .take            (take),
        .pc_step         (pc_step),
        .apb_req         (apb_req),
        .apb_rsp         (apb_rsp),
        .if_pkt          (if_pkt),
        .fetch_stall_req (fetch_stall_req)
    );

    inst_rom u_inst_rom (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    if_id_reg u_if_id_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .if_pkt (if_pkt),
        .take   (take),
        .id     (id)
    );

endmodule

// File: testbench/tb_fetch.sv
//##########################################################################
// tb_fetch
// testbench of the instruction-fetch front end. Drives random stall,
// bubble and flush commands and checks every packet that reaches decode
// against a model of the instruction ROM
//##########################################################################
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
();

    localparam int          CLK_PERIOD  = 40;
    localparam int          DRIVE_DLY   = 2;      // after the rising edge
    localparam int          RESET_CYC   = 3;
    localparam int          TIMEOUT_CYC = 50;
    localparam int          RANDOM_CYC  = 2000;
    localparam int          MIN_PKTS    = 100;
    localparam int unsigned RAND_SEED   = 11003;

    logic       clk;
    logic       rst_n;
    pipe_ctrl_t ctrl;
    pc_t        redirect_pc;
    fetch_pkt_t id;
    logic       fetch_stall_req;

    inst_t      rom_model [ROM_WORDS];
    int         pkt_count;          // valid packets checked so far
    pc_t        exp_pc;             // pc of the next packet decode should see
    pipe_ctrl_t prev_ctrl;
    pc_t        prev_redirect;
    fetch_pkt_t prev_id;
    logic       prev_stall_req;

    fetch_top DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .ctrl            (ctrl),
        .redirect_pc     (redirect_pc),
        .id              (id),
        .fetch_stall_req (fetch_stall_req)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // invalid nop at pc zero that flush and bubble leave behind
    function automatic fetch_pkt_t empty_slot();
        fetch_pkt_t pkt;
        pkt.pc    = 32'h0000_0000;
        pkt.inst  = NOP_INST;
        pkt.fault = 1'b0;
        pkt.valid = 1'b0;
        return pkt;
    endfunction

    // packet that decode should get for a given fetch address
    function automatic fetch_pkt_t expected_pkt(input pc_t pc);
        fetch_pkt_t        pkt;
        logic [ROM_AW-1:0] idx;
        idx       = pc[ROM_AW+1:2];
        pkt.pc    = pc;
        pkt.valid = 1'b1;
        if (pc < pc_t'(ROM_WORDS * 4)) begin
            pkt.inst  = rom_model[idx];
            pkt.fault = 1'b0;
        end else begin
            pkt.inst  = NOP_INST;       // past the end of the rom
            pkt.fault = 1'b1;
        end
        return pkt;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pkt(input fetch_pkt_t got, input fetch_pkt_t exp,
                             input string name);
        if (got !== exp) begin
            $display("ERROR: %s at %0t got pc=%h inst=%h fault=%h valid=%h",
                     name, $time, got.pc, got.inst, got.fault, got.valid);
            $display("ERROR: %s expected pc=%h inst=%h fault=%h valid=%h",
                     name, exp.pc, exp.inst, exp.fault, exp.valid);
            fail_run({name, " does not match the expected packet"});
        end
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp, input string name);
        if (got !== exp) begin
            $display("ERROR: %s at %0t got %h expected %h", name, $time, got, exp);
            fail_run({name, " is out of sequence"});
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("ERROR: %s at %0t got %h expected %h", name, $time, got, exp);
            fail_run({name, " has the wrong value"});
        end
    endtask

    // block until n more packets were checked, each within the timeout
    task automatic wait_packets(input int n);
        int goal;
        int last_count;
        int idle;
        goal       = pkt_count + n;
        last_count = pkt_count;
        idle       = 0;
        while (pkt_count < goal) begin
            @(posedge clk);
            if (pkt_count != last_count) begin
                last_count = pkt_count;
                idle       = 0;
            end else if (idle == TIMEOUT_CYC) begin
                fail_run("timed out waiting for an instruction to reach decode");
            end else begin
                idle = idle + 1;
            end
        end
    endtask

    task automatic run_random(input int cycles);
        int idle;
        int last_count;
        idle       = 0;
        last_count = pkt_count;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            #DRIVE_DLY;
            ctrl.flush  = (($urandom % 100) < 3);
            ctrl.stall  = (($urandom % 100) < 20);
            ctrl.bubble = (($urandom % 100) < 20);
            if (ctrl.flush)
                redirect_pc = pc_t'($urandom % ROM_WORDS) << 2;  // word aligned
            if (pkt_count != last_count) begin
                last_count = pkt_count;
                idle       = 0;
            end else if (idle == TIMEOUT_CYC) begin
                fail_run("no instruction reached decode for 50 cycles");
            end else begin
                idle = idle + 1;
            end
        end
    endtask

    // checker samples id half a cycle after the edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (prev_ctrl.flush) begin
                check_pkt(id, empty_slot(), "id");
                exp_pc = prev_redirect;             // restart on the new path
            end else if (prev_ctrl.stall) begin
                check_pkt(id, prev_id, "id");       // must hold
            end else if (prev_ctrl.bubble) begin
                check_pkt(id, empty_slot(), "id");
            end else begin
                // IF/ID took whatever fetch offered
                check_bit(prev_stall_req, !id.valid, "fetch_stall_req");
                if (id.valid) begin
                    check_pc(id.pc, exp_pc, "id.pc");
                    check_pkt(id, expected_pkt(exp_pc), "id");
                    exp_pc    = exp_pc + 32'd4;
                    pkt_count = pkt_count + 1;
                end
            end
        end
        prev_ctrl      = ctrl;
        prev_redirect  = redirect_pc;
        prev_id        = id;
        prev_stall_req = fetch_stall_req;
    end

    initial begin
        void'($urandom(RAND_SEED));
        rst_n          = 1'b0;
        ctrl           = '0;
        redirect_pc    = RESET_PC;
        pkt_count      = 0;
        exp_pc         = RESET_PC;
        prev_ctrl      = '0;
        prev_redirect  = RESET_PC;
        prev_id        = empty_slot();
        prev_stall_req = 1'b1;
        $readmemh("src/inst_rom.hex", rom_model);

        repeat (RESET_CYC) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // nothing for decode yet
        @(negedge clk);
        check_bit(fetch_stall_req, 1'b1, "fetch_stall_req");
        check_bit(id.valid, 1'b0, "id.valid");

        wait_packets(24);   // straight-line run from RESET_PC

        run_random(RANDOM_CYC);

        // quiet tail so the last path drains
        @(posedge clk);
        #DRIVE_DLY;
        ctrl = '0;
        wait_packets(4);

        if (pkt_count < MIN_PKTS) begin
            fail_run("too few instructions reached decode");
        end else begin
            $display("checked %0d instructions", pkt_count);
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: src/inst_rom.hex
// one 32-bit instruction word per line in hex, word index 0 first
10000093
10100113
10200193
10300213
10400293
10500313
10600393
10700413
10800493
10900513
10a00593
10b00613
10c00693
10d00713
10e00793
10f00813
11000893
11100913
11200993
11300a13
11400a93
11500b13
11600b93
11700c13
11800c93
11900d13
11a00d93
11b00e13
11c00e93
11d00f13
11e00f93
11f00093

// File: sources.f
src/fetch_pkg.sv
src/pc_gen.sv
src/fetch_fsm.sv
src/inst_rom.sv
src/if_id_reg.sv
src/fetch_top.sv
testbench/tb_fetch.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --top-module tb_fetch -f sources.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_fetch > sim.log 2>&1 || true
cat sim.log

grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
